/* bt_acl_pkg.sv */
// shared constants of the ACL receive data path
// buffer word geometry and payload length limits

package bt_acl_pkg;

  // buffer word layout
  localparam int bytes_per_word = 4;

  // DH5 carries the longest ACL payload
  localparam int max_pyld_bytes = 339;

  // default widths, overridden from the top level
  localparam int default_addr_w = 8;   // 256 words per bank
  localparam int default_data_w = 32;  // one buffer word
  localparam int default_len_w  = 10;  // byte count up to 1023

endpackage

/* sram256x32_1p.sv */
// behavioral single-port synchronous RAM
// registered read data, write when CS and WE

`timescale 1ns/1ps

module sram256x32_1p #(
  parameter int ADDR_W = bt_acl_pkg::default_addr_w,
  parameter int DATA_W = bt_acl_pkg::default_data_w
) (
  input  logic [ADDR_W-1:0] A,
  input  logic [DATA_W-1:0] DIN,
  input  logic              CLK,
  input  logic              WE,
  input  logic              CS,
  output logic [DATA_W-1:0] DOUT
);

  logic [DATA_W-1:0] mem [2**ADDR_W];

  always_ff @(posedge CLK)
  begin
    if (CS && WE)
      mem[A] <= DIN;
  end

  // read port holds its last word while deselected
  always_ff @(posedge CLK)
  begin
    if (CS && !WE)
      DOUT <= mem[A];
  end

endmodule

/* acl_rx_packer.sv */
// payload byte to buffer word packer
// little-endian lanes, zero-filled final word, write strobe and address

`timescale 1ns/1ps

module acl_rx_packer #(
  parameter int ADDR_W = bt_acl_pkg::default_addr_w,
  parameter int DATA_W = bt_acl_pkg::default_data_w,
  parameter int LEN_W  = bt_acl_pkg::default_len_w
) (
  input  logic              clk_6M,
  input  logic              rstz,
  input  logic              pyld_start_p,
  input  logic              byte_valid_p,
  input  logic [7:0]        byte_data,
  input  logic [LEN_W-1:0]  dec_pylen_byte,
  output logic [ADDR_W-1:0] lnctrl_addr,
  output logic [DATA_W-1:0] lnctrl_din,
  output logic              lnctrl_we
);

  import bt_acl_pkg::*;

  localparam int lane_w = $clog2(bytes_per_word);

  logic [LEN_W-1:0]  byte_cnt;
  logic [LEN_W-1:0]  byte_cnt_nxt;
  logic [lane_w-1:0] lane;
  logic              take;
  logic              word_full;
  logic              last_byte;
  logic [DATA_W-1:0] word_q;

  assign take         = byte_valid_p & ~pyld_start_p;   // bytes follow the start pulse
  assign byte_cnt_nxt = byte_cnt + 1'b1;
  assign lane         = byte_cnt[lane_w-1:0];
  assign word_full    = (lane == lane_w'(bytes_per_word - 1));
  assign last_byte    = (byte_cnt_nxt == dec_pylen_byte);

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      byte_cnt <= '0;
    else if (pyld_start_p)
      byte_cnt <= '0;
    else if (take)
      byte_cnt <= byte_cnt_nxt;
  end

  // first byte of a word clears the upper lanes
  always_ff @(posedge clk_6M)
  begin
    if (take)
    begin
      if (lane == '0)
        word_q <= DATA_W'(byte_data);
      else
        word_q[8*lane +: 8] <= byte_data;
    end
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      lnctrl_we <= 1'b0;
    else
      lnctrl_we <= take & (word_full | last_byte);   // full word or flush
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      lnctrl_addr <= '0;
    else if (pyld_start_p)
      lnctrl_addr <= '0;
    else if (lnctrl_we)
      lnctrl_addr <= lnctrl_addr + 1'b1;   // step after each write
  end

  assign lnctrl_din = word_q;

  // bytes arrive far apart, so strobes never touch
  a_we_single : assert property (@(posedge clk_6M) disable iff (!rstz)
    lnctrl_we |=> !lnctrl_we);

endmodule

/* acl_rx_buf_ctrl.sv */
// ACL receive ping-pong buffer controller
// bank ownership, packet lengths, empty flags, flow bit and read end
// holds the two payload RAMs

`timescale 1ns/1ps

module acl_rx_buf_ctrl #(
  parameter int ADDR_W = bt_acl_pkg::default_addr_w,
  parameter int DATA_W = bt_acl_pkg::default_data_w,
  parameter int LEN_W  = bt_acl_pkg::default_len_w
) (
  input  logic              clk_6M,
  input  logic              rstz,
  input  logic              corre_trgp,
  input  logic              connsactive,
  input  logic              tx_packet_st_p,
  input  logic              ms_tslot_p,
  input  logic              pk_encode,
  input  logic              dec_hecgood,
  input  logic              dec_crcgood,
  input  logic              pktype_data,
  input  logic [LEN_W-1:0]  dec_pylen_byte,
  input  logic [ADDR_W-1:0] lnctrl_addr,
  input  logic [DATA_W-1:0] lnctrl_din,
  input  logic              lnctrl_we,
  input  logic [ADDR_W-1:0] bsm_addr,
  input  logic              bsm_cs,
  input  logic              bsm_valid_p,
  output logic [DATA_W-1:0] bsm_dout,
  output logic              bsm_read_endp,
  output logic              rd_buf_empty,
  output logic              rx_buf_empty
);

  import bt_acl_pkg::*;

  localparam int lane_w = $clog2(bytes_per_word);

  logic              bank_sel;    // 0: bank 0 read side, bank 1 link side
  logic              link_bank;
  logic              rx_ind;      // packet received in this slot pair
  logic [1:0]        bank_empty;
  logic [LEN_W-1:0]  bank_len [2];
  logic [ADDR_W-1:0] ram_a [2];
  logic [DATA_W-1:0] ram_din [2];
  logic [DATA_W-1:0] ram_dout [2];
  logic [1:0]        ram_we;
  logic [1:0]        ram_cs;
  logic              hdr_ok;
  logic              len_cap;
  logic              accept;
  logic [LEN_W-1:0]  rd_len;
  logic [LEN_W-1:0]  rd_words;
  logic [ADDR_W-1:0] end_addr;

  assign link_bank = ~bank_sel;
  assign hdr_ok    = ~pk_encode & dec_hecgood & dec_crcgood;
  assign len_cap   = ms_tslot_p & hdr_ok;
  assign accept    = tx_packet_st_p & hdr_ok & pktype_data & rx_ind;

  for (genvar b = 0; b < 2; b++)
  begin : g_bank
    localparam logic bank_id = 1'(b);

    // link side takes the packer port, chip select follows write enable
    assign ram_a[b]   = (link_bank == bank_id) ? lnctrl_addr : bsm_addr;
    assign ram_din[b] = (link_bank == bank_id) ? lnctrl_din : '0;
    assign ram_we[b]  = (link_bank == bank_id) & lnctrl_we;
    assign ram_cs[b]  = (link_bank == bank_id) ? lnctrl_we : bsm_cs;

    always_ff @(posedge clk_6M or negedge rstz)
    begin
      if (!rstz)
        bank_len[b] <= '0;
      else if (len_cap && link_bank == bank_id)
        bank_len[b] <= dec_pylen_byte;   // latched at the slot boundary
    end

    always_ff @(posedge clk_6M or negedge rstz)
    begin
      if (!rstz)
        bank_empty[b] <= 1'b1;
      else if (bsm_read_endp && bank_sel == bank_id)
        bank_empty[b] <= 1'b1;   // drained by the host
      else if (accept && link_bank == bank_id)
        bank_empty[b] <= 1'b0;   // packet kept
    end

    sram256x32_1p #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
    ) u_ram (
      .A    (ram_a[b]),
      .DIN  (ram_din[b]),
      .CLK  (clk_6M),
      .WE   (ram_we[b]),
      .CS   (ram_cs[b]),
      .DOUT (ram_dout[b])
    );

    // the flow bit keeps the peer off a bank that still holds a packet
    a_wr_free_bank : assert property (@(posedge clk_6M) disable iff (!rstz)
      ram_we[b] |-> bank_empty[b]);

    // stored length fits a DH5 payload
    a_len_max : assert property (@(posedge clk_6M) disable iff (!rstz)
      (len_cap && link_bank == bank_id) |=> (bank_len[b] <= LEN_W'(max_pyld_bytes)));
  end

  assign bsm_dout     = ram_dout[bank_sel];
  assign rd_buf_empty = bank_empty[bank_sel];

  // last word address of the read side, length rounded up to words
  assign rd_len        = bank_len[bank_sel];
  assign rd_words      = (rd_len + LEN_W'(bytes_per_word - 1)) >> lane_w;
  assign end_addr      = ADDR_W'(rd_words - 1'b1);
  assign bsm_read_endp = bsm_valid_p & (bsm_addr >= end_addr);

  // swap after a read, or hand a fresh packet over when the read side is idle
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      bank_sel <= 1'b0;
    else if (bsm_read_endp || (accept && bank_empty[bank_sel]))
      bank_sel <= ~bank_sel;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      rx_ind <= 1'b0;
    else if (corre_trgp && connsactive)
      rx_ind <= 1'b1;
    else if (tx_packet_st_p)
      rx_ind <= 1'b0;
  end

  // flow bit for the next transmission
  // 1 means a bank is free and the peer may send data
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      rx_buf_empty <= 1'b1;
    else if (tx_packet_st_p)
      rx_buf_empty <= bank_empty[bank_sel];
  end

endmodule

/* acl_rx_reader.sv */
// host side buffer reader
// chip select per word, valid one cycle later, stop on read end

`timescale 1ns/1ps

module acl_rx_reader #(
  parameter int ADDR_W = bt_acl_pkg::default_addr_w,
  parameter int DATA_W = bt_acl_pkg::default_data_w
) (
  input  logic              clk_6M,
  input  logic              rstz,
  input  logic              rd_start_p,
  input  logic              rd_buf_empty,
  input  logic [DATA_W-1:0] bsm_dout,
  input  logic              bsm_read_endp,
  output logic [ADDR_W-1:0] bsm_addr,
  output logic              bsm_cs,
  output logic              bsm_valid_p,
  output logic [DATA_W-1:0] rd_data,
  output logic              rd_valid
);

  logic busy;
  logic start;
  logic next_word;

  assign start     = rd_start_p & ~rd_buf_empty & ~busy;
  assign next_word = bsm_valid_p & ~bsm_read_endp;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      busy <= 1'b0;
    else if (start)
      busy <= 1'b1;
    else if (bsm_read_endp)
      busy <= 1'b0;
  end

  // next select once the previous word is back
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      bsm_cs <= 1'b0;
    else
      bsm_cs <= start | next_word;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      bsm_valid_p <= 1'b0;
    else
      bsm_valid_p <= bsm_cs;   // RAM read latency
  end

  // address holds through the valid cycle
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      bsm_addr <= '0;
    else if (start)
      bsm_addr <= '0;
    else if (next_word)
      bsm_addr <= bsm_addr + 1'b1;
  end

  assign rd_data  = bsm_dout;
  assign rd_valid = bsm_valid_p;

endmodule

/* acl_rx_top.sv */
// ACL receive data path top level
// packer, ping-pong buffer controller and host reader

`timescale 1ns/1ps

module acl_rx_top #(
  parameter int ADDR_W = bt_acl_pkg::default_addr_w,
  parameter int DATA_W = bt_acl_pkg::default_data_w,
  parameter int LEN_W  = bt_acl_pkg::default_len_w
) (
  input  logic              clk_6M,
  input  logic              rstz,
  input  logic              corre_trgp,
  input  logic              connsactive,
  input  logic              tx_packet_st_p,
  input  logic              ms_tslot_p,
  input  logic              pk_encode,
  input  logic              dec_hecgood,
  input  logic              dec_crcgood,
  input  logic              pktype_data,
  input  logic [LEN_W-1:0]  dec_pylen_byte,
  input  logic              pyld_start_p,
  input  logic              byte_valid_p,
  input  logic [7:0]        byte_data,
  input  logic              rd_start_p,
  output logic [DATA_W-1:0] rd_data,
  output logic              rd_valid,
  output logic              rx_buf_empty
);

  logic [ADDR_W-1:0] lnctrl_addr;
  logic [DATA_W-1:0] lnctrl_din;
  logic              lnctrl_we;
  logic [ADDR_W-1:0] bsm_addr;
  logic              bsm_cs;
  logic              bsm_valid_p;
  logic [DATA_W-1:0] bsm_dout;
  logic              bsm_read_endp;
  logic              rd_buf_empty;

  acl_rx_packer #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W),
    .LEN_W  (LEN_W)
  ) u_packer (
    .clk_6M         (clk_6M),
    .rstz           (rstz),
    .pyld_start_p   (pyld_start_p),
    .byte_valid_p   (byte_valid_p),
    .byte_data      (byte_data),
    .dec_pylen_byte (dec_pylen_byte),
    .lnctrl_addr    (lnctrl_addr),
    .lnctrl_din     (lnctrl_din),
    .lnctrl_we      (lnctrl_we)
  );

  acl_rx_buf_ctrl #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W),
    .LEN_W  (LEN_W)
  ) u_buf_ctrl (
    .clk_6M         (clk_6M),
    .rstz           (rstz),
    .corre_trgp     (corre_trgp),
    .connsactive    (connsactive),
    .tx_packet_st_p (tx_packet_st_p),
    .ms_tslot_p     (ms_tslot_p),
    .pk_encode      (pk_encode),
    .dec_hecgood    (dec_hecgood),
    .dec_crcgood    (dec_crcgood),
    .pktype_data    (pktype_data),
    .dec_pylen_byte (dec_pylen_byte),
    .lnctrl_addr    (lnctrl_addr),
    .lnctrl_din     (lnctrl_din),
    .lnctrl_we      (lnctrl_we),
    .bsm_addr       (bsm_addr),
    .bsm_cs         (bsm_cs),
    .bsm_valid_p    (bsm_valid_p),
    .bsm_dout       (bsm_dout),
    .bsm_read_endp  (bsm_read_endp),
    .rd_buf_empty   (rd_buf_empty),
    .rx_buf_empty   (rx_buf_empty)
  );

  acl_rx_reader #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_reader (
    .clk_6M        (clk_6M),
    .rstz          (rstz),
    .rd_start_p    (rd_start_p),
    .rd_buf_empty  (rd_buf_empty),
    .bsm_dout      (bsm_dout),
    .bsm_read_endp (bsm_read_endp),
    .bsm_addr      (bsm_addr),
    .bsm_cs        (bsm_cs),
    .bsm_valid_p   (bsm_valid_p),
    .rd_data       (rd_data),
    .rd_valid      (rd_valid)
  );

endmodule

/* tb_acl_rx.sv */
// testbench for the ACL receive data path
// packet table, bank reference model, check task and cycle timeout

`timescale 1ns/1ps

module tb_acl_rx;

  import bt_acl_pkg::*;

  typedef struct packed {
    int len;
    bit hec;
    bit crc;
    bit data;
    bit enc;
    bit corr;
    bit rd;
  } row_t;

  localparam int n_rows = 15;

  // len, hec, crc, data type, encoding, correlation, read after
  row_t pkt_table [n_rows] = '{
    '{16,  1, 1, 1, 0, 1, 1},  // whole words
    '{13,  1, 1, 1, 0, 1, 1},
    '{6,   1, 1, 1, 0, 1, 1},
    '{3,   1, 1, 1, 0, 1, 1},  // single partial word
    '{20,  0, 1, 1, 0, 1, 1},  // bad HEC
    '{9,   1, 0, 1, 0, 1, 1},  // bad CRC
    '{8,   1, 1, 0, 0, 1, 1},  // no data
    '{12,  1, 1, 1, 1, 1, 1},  // encoding
    '{10,  1, 1, 1, 0, 0, 1},  // no correlation
    '{24,  1, 1, 1, 0, 1, 0},  // held on read side
    '{17,  1, 1, 1, 0, 1, 1},  // link side, both banks full
    '{40,  1, 1, 1, 0, 1, 1},
    '{7,   1, 1, 1, 0, 1, 1},
    '{11,  1, 0, 1, 0, 1, 1},
    '{339, 1, 1, 1, 0, 1, 1}   // DH5
  };

  logic        clk_6M;
  logic        rstz;
  logic        corre_trgp;
  logic        connsactive;
  logic        tx_packet_st_p;
  logic        ms_tslot_p;
  logic        pk_encode;
  logic        dec_hecgood;
  logic        dec_crcgood;
  logic        pktype_data;
  logic [9:0]  dec_pylen_byte;
  logic        pyld_start_p;
  logic        byte_valid_p;
  logic [7:0]  byte_data;
  logic        rd_start_p;
  logic [31:0] rd_data;
  logic        rd_valid;
  logic        rx_buf_empty;

  // reference model of the two banks
  int          m_sel;
  bit          m_empty [2];
  int          m_len [2];
  logic [31:0] m_mem [2][256];
  logic [7:0]  pkt [512];

  integer      seed;
  int          errors;
  int          checks;
  int          cycles = 0;
  int          limit = 0;

  acl_rx_top acl_rx_top_inst (
    .clk_6M         (clk_6M),
    .rstz           (rstz),
    .corre_trgp     (corre_trgp),
    .connsactive    (connsactive),
    .tx_packet_st_p (tx_packet_st_p),
    .ms_tslot_p     (ms_tslot_p),
    .pk_encode      (pk_encode),
    .dec_hecgood    (dec_hecgood),
    .dec_crcgood    (dec_crcgood),
    .pktype_data    (pktype_data),
    .dec_pylen_byte (dec_pylen_byte),
    .pyld_start_p   (pyld_start_p),
    .byte_valid_p   (byte_valid_p),
    .byte_data      (byte_data),
    .rd_start_p     (rd_start_p),
    .rd_data        (rd_data),
    .rd_valid       (rd_valid),
    .rx_buf_empty   (rx_buf_empty)
  );

  always #50 clk_6M = ~clk_6M;   // 10 MHz stand-in for the 6 MHz clock

  always @(posedge clk_6M)
  begin
    cycles++;
    if (limit > 0 && cycles > limit)
    begin
      $display("timeout: run did not end within %0d clock cycles", limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic send_payload(input row_t row);
    int          link;
    logic [31:0] w;
    link           = 1 - m_sel;
    dec_pylen_byte = 10'(row.len);
    dec_hecgood    = row.hec;
    dec_crcgood    = row.crc;
    pktype_data    = row.data;
    pk_encode      = row.enc;
    if (row.corr)
    begin
      corre_trgp = 1'b1;
      @(negedge clk_6M);
      corre_trgp = 1'b0;
    end
    @(negedge clk_6M);
    pyld_start_p = 1'b1;
    @(negedge clk_6M);
    pyld_start_p = 1'b0;
    for (int i = 0; i < row.len; i++)
    begin
      pkt[i]       = 8'($random(seed));
      byte_data    = pkt[i];
      byte_valid_p = 1'b1;
      @(negedge clk_6M);
      byte_valid_p = 1'b0;   // one idle cycle between bytes
      @(negedge clk_6M);
    end
    // little-endian words, zero past the last byte
    for (int i = 0; i < (row.len + bytes_per_word - 1) / bytes_per_word; i++)
    begin
      w = '0;
      for (int k = 0; k < bytes_per_word; k++)
        if (i * bytes_per_word + k < row.len)
          w[8*k +: 8] = pkt[i * bytes_per_word + k];
      m_mem[link][i] = w;
    end
  endtask

  task automatic close_slot(input row_t row, output bit accepted);
    bit hdr_ok;
    bit exp_flow;
    hdr_ok = !row.enc && row.hec && row.crc;
    repeat (2) @(negedge clk_6M);
    ms_tslot_p = 1'b1;
    @(negedge clk_6M);
    ms_tslot_p = 1'b0;
    if (hdr_ok)
      m_len[1 - m_sel] = row.len;   // length goes with the link bank
    repeat (2) @(negedge clk_6M);
    tx_packet_st_p = 1'b1;
    @(negedge clk_6M);
    tx_packet_st_p = 1'b0;
    exp_flow = m_empty[m_sel];
    accepted = hdr_ok && row.data && row.corr;
    if (accepted)
    begin
      m_empty[1 - m_sel] = 1'b0;
      if (m_empty[m_sel])
        m_sel = 1 - m_sel;   // idle read side takes the new packet
    end
    check_value("rx_buf_empty", 32'(rx_buf_empty), 32'(exp_flow));
  endtask

  task automatic read_back();
    int n;
    int got;
    bit extra;
    n = 0;
    if (!m_empty[m_sel])
      n = (m_len[m_sel] + bytes_per_word - 1) / bytes_per_word;
    rd_start_p = 1'b1;
    @(negedge clk_6M);
    rd_start_p = 1'b0;
    got = 0;
    while (got < n)
    begin
      @(negedge clk_6M);
      if (rd_valid)
      begin
        check_value("rd_data", rd_data, m_mem[m_sel][got]);
        got++;
      end
    end
    // no word past the packet end
    extra = 1'b0;
    repeat (8)
    begin
      @(negedge clk_6M);
      extra = extra | rd_valid;
    end
    check_value("rd_valid", 32'(extra), 32'(0));
    if (n > 0)
    begin
      m_empty[m_sel] = 1'b1;
      m_sel = 1 - m_sel;
    end
  endtask

  task automatic run_row(input int r);
    row_t row;
    bit   accepted;
    int   errs_before;
    row         = pkt_table[r];
    errs_before = errors;
    send_payload(row);
    close_slot(row, accepted);
    if (row.rd)
      read_back();
    if (errors == errs_before)
      $display("row %0d: len %0d accepted %0d ok", r, row.len, accepted);
    else
      $display("row %0d: len %0d accepted %0d, %0d errors", r, row.len, accepted,
               errors - errs_before);
  endtask

  initial
  begin
    clk_6M         = 1'b0;
    rstz           = 1'b0;
    corre_trgp     = 1'b0;
    connsactive    = 1'b1;
    tx_packet_st_p = 1'b0;
    ms_tslot_p     = 1'b0;
    pk_encode      = 1'b0;
    dec_hecgood    = 1'b0;
    dec_crcgood    = 1'b0;
    pktype_data    = 1'b0;
    dec_pylen_byte = '0;
    pyld_start_p   = 1'b0;
    byte_valid_p   = 1'b0;
    byte_data      = '0;
    rd_start_p     = 1'b0;
    seed           = 21573;
    errors         = 0;
    checks         = 0;
    m_sel          = 0;
    m_empty[0]     = 1'b1;
    m_empty[1]     = 1'b1;
    m_len[0]       = 0;
    m_len[1]       = 0;
    // two cycles per byte, a read of half that, plus slot overhead
    limit = 32;
    for (int r = 0; r < n_rows; r++)
      limit += 4 * pkt_table[r].len + 64;
    repeat (8) @(negedge clk_6M);
    rstz = 1'b1;
    check_value("rx_buf_empty", 32'(rx_buf_empty), 32'(1));
    check_value("rd_valid", 32'(rd_valid), 32'(0));
    for (int r = 0; r < n_rows; r++)
      run_row(r);
    $display("rows %0d, checks %0d, errors %0d", n_rows, checks, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

/* all.f */
bt_acl_pkg.sv
sram256x32_1p.sv
acl_rx_packer.sv
acl_rx_buf_ctrl.sv
acl_rx_reader.sv
acl_rx_top.sv
tb_acl_rx.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ACL receive testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_acl_rx -f all.f -o sim_acl_rx

# the log decides pass or fail
./obj_dir/sim_acl_rx > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASSED" sim.log
then
  exit 0
fi
exit 1
